//--- project.f
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/cpu_core.sv
verification/tb_cpu_core.sv

//--- rtl/core_pkg.sv
package core_pkg;

    localparam int xlen    = 32;
    localparam int reg_num = 32;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [xlen-1:0] u32_t;

    // ****************************************
    // instruction word
    // ****************************************

    typedef struct packed {
        logic [16:0] opcode17;
        reg_idx_t    rk;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } inst_r3_t;

    typedef struct packed {
        logic [9:0]  opcode10;
        logic [11:0] imm12;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } inst_ri12_t;

    typedef union packed {
        inst_r3_t   r3;
        inst_ri12_t ri12;
    } inst_t;

    // three-register format, bits 31:15.
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_slt   = 17'h00024;
    localparam logic [16:0] op_sltu  = 17'h00025;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;

    // two-register plus imm12 format, bits 31:22.
    localparam logic [9:0] op_slti   = 10'h008;
    localparam logic [9:0] op_sltui  = 10'h009;
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_andi   = 10'h00d;
    localparam logic [9:0] op_ori    = 10'h00e;
    localparam logic [9:0] op_xori   = 10'h00f;

    typedef enum logic [3:0] {
        add,
        sub,
        slt,
        sltu,
        and_op,
        or_op,
        xor_op
    } alu_op_t;

    // ****************************************
    // stage records
    // ****************************************

    typedef struct packed {
        u32_t  pc;
        inst_t inst;
    } inst_in_t;

    typedef struct packed {
        u32_t     pc;
        inst_t    inst;
        alu_op_t  alu_op;
        u32_t     src_a;
        u32_t     src_b;
        reg_idx_t rd;
        logic     rf_we;
        logic     illegal;
    } decode_execute_pass_t;

    typedef struct packed {
        u32_t     pc;
        inst_t    inst;
        reg_idx_t rd;
        logic     rf_we;
        logic     illegal;
        u32_t     result;
    } execute_writeback_pass_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        u32_t     data;
    } forward_req_t;

    typedef struct packed {
        u32_t     pc;
        u32_t     inst;
        logic     rf_wen;
        reg_idx_t rf_wnum;
        u32_t     rf_wdata;
        logic     illegal;
    } commit_t;

endpackage

//--- rtl/cpu_core.sv
module cpu_core
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  inst_in_t in_data,

    output logic     commit_valid,
    input  logic     commit_ready,
    output commit_t  commit
);

    decode_execute_pass_t    pass_id;
    execute_writeback_pass_t pass_ex;
    forward_req_t            ex_fwd;
    forward_req_t            wb_fwd;

    logic     id_valid, ex_valid;
    logic     ex_rdy_in, wb_rdy_in;

    reg_idx_t rj, rk, rf_rd;
    u32_t     rj_data, rk_data, rf_data;
    logic     rf_we;

    reg_file u_reg_file (
        .clk, .rst_n,
        .rj,
        .rk,
        .rj_data,
        .rk_data,
        .we(rf_we),
        .rd(rf_rd),
        .wr_data(rf_data)
    );

    // ****************************************
    // pipeline
    // ****************************************

    decode_stage u_decode (
        .clk, .rst_n,
        .in_valid,
        .in_ready,
        .in_data,
        .rj,
        .rk,
        .rj_data,
        .rk_data,
        .ex_fwd,
        .wb_fwd,
        .next_ready(ex_rdy_in),
        .out_valid(id_valid),
        .pass_out(pass_id)
    );

    execute_stage u_execute (
        .clk, .rst_n,
        .in_valid(id_valid),
        .in_ready(ex_rdy_in),
        .pass_in(pass_id),
        .next_ready(wb_rdy_in),
        .out_valid(ex_valid),
        .pass_out(pass_ex),
        .fwd(ex_fwd)
    );

    writeback_stage u_writeback (
        .clk, .rst_n,
        .in_valid(ex_valid),
        .in_ready(wb_rdy_in),
        .pass_in(pass_ex),
        .commit_valid,
        .commit_ready,
        .commit,
        .rf_we,
        .rf_rd,
        .rf_data,
        .fwd(wb_fwd)
    );

endmodule

//--- rtl/decode_stage.sv
module decode_stage
    import core_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 in_valid,
    output logic                 in_ready,
    input  inst_in_t             in_data,

    output reg_idx_t             rj,
    output reg_idx_t             rk,
    input  u32_t                 rj_data,
    input  u32_t                 rk_data,

    input  forward_req_t         ex_fwd,
    input  forward_req_t         wb_fwd,

    input  logic                 next_ready,
    output logic                 out_valid,
    output decode_execute_pass_t pass_out
);

    logic     valid_q;
    inst_in_t inst_q;

    alu_op_t  alu_op;
    logic     use_imm;
    logic     sext;
    logic     legal;
    u32_t     imm_ext;
    u32_t     rj_val;
    u32_t     rk_val;

    // the younger result in execute wins over writeback.
    function automatic u32_t pick_operand(reg_idx_t idx, u32_t rf_val,
                                          forward_req_t ex, forward_req_t wb);
        u32_t val;
        val = rf_val;
        if (ex.valid && ex.rd == idx) begin
            val = ex.data;
        end else if (wb.valid && wb.rd == idx) begin
            val = wb.data;
        end
        return val;
    endfunction

    assign in_ready  = !valid_q || next_ready;
    assign out_valid = valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            inst_q <= in_data;
        end
    end

    // ****************************************
    // opcode match, both formats
    // ****************************************

    always_comb begin
        alu_op  = add;
        use_imm = 1'b0;
        sext    = 1'b0;
        legal   = 1'b1;
        case (inst_q.inst.r3.opcode17)
            op_add_w: alu_op = add;
            op_sub_w: alu_op = sub;
            op_slt:   alu_op = slt;
            op_sltu:  alu_op = sltu;
            op_and:   alu_op = and_op;
            op_or:    alu_op = or_op;
            op_xor:   alu_op = xor_op;
            default: begin
                use_imm = 1'b1;
                sext    = 1'b1;
                case (inst_q.inst.ri12.opcode10)
                    op_addi_w: alu_op = add;
                    op_slti:   alu_op = slt;
                    op_sltui:  alu_op = sltu;
                    op_andi: begin
                        alu_op = and_op;
                        sext   = 1'b0;
                    end
                    op_ori: begin
                        alu_op = or_op;
                        sext   = 1'b0;
                    end
                    op_xori: begin
                        alu_op = xor_op;
                        sext   = 1'b0;
                    end
                    default: legal = 1'b0;
                endcase
            end
        endcase
    end

    assign imm_ext = sext ? {{(xlen-12){inst_q.inst.ri12.imm12[11]}}, inst_q.inst.ri12.imm12}
                          : {{(xlen-12){1'b0}}, inst_q.inst.ri12.imm12};

    assign rj = inst_q.inst.r3.rj;
    assign rk = inst_q.inst.r3.rk;

    assign rj_val = pick_operand(rj, rj_data, ex_fwd, wb_fwd);
    assign rk_val = pick_operand(rk, rk_data, ex_fwd, wb_fwd);

    always_comb begin
        pass_out.pc      = inst_q.pc;
        pass_out.inst    = inst_q.inst;
        pass_out.alu_op  = alu_op;
        pass_out.src_a   = rj_val;
        pass_out.src_b   = use_imm ? imm_ext : rk_val;
        pass_out.rd      = inst_q.inst.r3.rd;
        pass_out.rf_we   = legal && inst_q.inst.r3.rd != '0; // r0 is never written.
        pass_out.illegal = !legal;
    end

endmodule

//--- rtl/execute_stage.sv
module execute_stage
    import core_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    in_valid,
    output logic                    in_ready,
    input  decode_execute_pass_t    pass_in,

    input  logic                    next_ready,
    output logic                    out_valid,
    output execute_writeback_pass_t pass_out,

    output forward_req_t            fwd
);

    logic                    valid_q;
    execute_writeback_pass_t pass_q;
    u32_t                    alu_res;
    logic                    lt_signed;
    logic                    lt_unsigned;

    assign in_ready  = !valid_q || next_ready;
    assign out_valid = valid_q;
    assign pass_out  = pass_q;

    // ****************************************
    // ALU
    // ****************************************

    assign lt_signed   = $signed(pass_in.src_a) < $signed(pass_in.src_b);
    assign lt_unsigned = pass_in.src_a < pass_in.src_b;

    always_comb begin
        case (pass_in.alu_op)
            add:     alu_res = pass_in.src_a + pass_in.src_b; // wraps at 32 bits.
            sub:     alu_res = pass_in.src_a - pass_in.src_b;
            slt:     alu_res = {{(xlen-1){1'b0}}, lt_signed};
            sltu:    alu_res = {{(xlen-1){1'b0}}, lt_unsigned};
            and_op:  alu_res = pass_in.src_a & pass_in.src_b;
            or_op:   alu_res = pass_in.src_a | pass_in.src_b;
            xor_op:  alu_res = pass_in.src_a ^ pass_in.src_b;
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            pass_q.pc      <= pass_in.pc;
            pass_q.inst    <= pass_in.inst;
            pass_q.rd      <= pass_in.rd;
            pass_q.rf_we   <= pass_in.rf_we;
            pass_q.illegal <= pass_in.illegal;
            pass_q.result  <= pass_in.illegal ? '0 : alu_res; // illegal commits a zero.
        end
    end

    assign fwd.valid = valid_q && pass_q.rf_we;
    assign fwd.rd    = pass_q.rd;
    assign fwd.data  = pass_q.result;

endmodule

//--- rtl/reg_file.sv
module reg_file
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  reg_idx_t rj,
    input  reg_idx_t rk,
    output u32_t     rj_data,
    output u32_t     rk_data,

    input  logic     we,
    input  reg_idx_t rd,
    input  u32_t     wr_data
);

    u32_t regs [reg_num];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_num; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wr_data;
        end
    end

    // a write in the same cycle is seen through the writeback forward.
    assign rj_data = (rj == '0) ? '0 : regs[rj];
    assign rk_data = (rk == '0) ? '0 : regs[rk];

endmodule

//--- rtl/writeback_stage.sv
module writeback_stage
    import core_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    in_valid,
    output logic                    in_ready,
    input  execute_writeback_pass_t pass_in,

    output logic                    commit_valid,
    input  logic                    commit_ready,
    output commit_t                 commit,

    output logic                    rf_we,
    output reg_idx_t                rf_rd,
    output u32_t                    rf_data,

    output forward_req_t            fwd
);

    logic                    valid_q;
    execute_writeback_pass_t rec_q;

    assign in_ready     = !valid_q || commit_ready;
    assign commit_valid = valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            rec_q <= pass_in;
        end
    end

    always_comb begin
        commit.pc       = rec_q.pc;
        commit.inst     = rec_q.inst;
        commit.rf_wen   = rec_q.rf_we;
        commit.rf_wnum  = rec_q.rd;
        commit.rf_wdata = rec_q.result;
        commit.illegal  = rec_q.illegal;
    end

    // the register file is written on the commit handshake only.
    assign rf_we   = valid_q && commit_ready && rec_q.rf_we;
    assign rf_rd   = rec_q.rd;
    assign rf_data = rec_q.result;

    assign fwd.valid = valid_q && rec_q.rf_we;
    assign fwd.rd    = rec_q.rd;
    assign fwd.data  = rec_q.result;

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_cpu_core -f project.f -o sim_cpu_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_cpu_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF -- '*** PASSED ***'; then
    exit 0
fi
exit 1

//--- verification/tb_cpu_core.sv
module tb_cpu_core
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int nrows          = 28;
    localparam int timeout_cycles = 2 * nrows * 20 + 200;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    logic     in_ready;
    inst_in_t in_data;
    logic     commit_valid;
    logic     commit_ready;
    commit_t  commit;

    logic [31:0] tab_pc    [nrows];
    logic [31:0] tab_inst  [nrows];
    logic [31:0] tab_wen   [nrows];
    logic [31:0] tab_wnum  [nrows];
    logic [31:0] tab_wdata [nrows];
    logic [31:0] tab_ill   [nrows];
    int          tab_group [nrows];
    logic        idle_gap  [nrows];

    int   nrow          = 0;
    int   cycle         = 0;
    int   seen          = 0;
    int   checks        = 0;
    int   errors        = 0;
    int   grp_err_start = 0;
    logic random_mode   = 1'b0;
    int   accept_q [$];

    cpu_core cpu_core_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] r3_word(input logic [16:0] op, input int rd, rj, rk);
        return {op, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] ri12_word(input logic [9:0] op, input int rd, rj,
                                              input logic [11:0] imm);
        return {op, imm, 5'(rj), 5'(rd)};
    endfunction

    function automatic string group_name(input int g);
        case (g)
            0:       return "operand load";
            1:       return "three-register ops";
            2:       return "imm12 extension";
            3:       return "forwarding chain";
            default: return "r0 and illegal";
        endcase
    endfunction

    task automatic add_row(input int grp, input logic [31:0] inst, input logic [31:0] wen,
                           input logic [31:0] wnum, input logic [31:0] wdata,
                           input logic [31:0] ill);
        tab_pc[nrow]    = 32'h1c00_0000 + 32'(nrow * 4);
        tab_inst[nrow]  = inst;
        tab_wen[nrow]   = wen;
        tab_wnum[nrow]  = wnum;
        tab_wdata[nrow] = wdata;
        tab_ill[nrow]   = ill;
        tab_group[nrow] = grp;
        nrow++;
    endtask

    // ****************************************
    // stimulus table
    // ****************************************

    task automatic build_table();
        add_row(0, ri12_word(op_addi_w, 1, 0, 12'hffb), 1, 1, 32'hffff_fffb, 0);
        add_row(0, ri12_word(op_addi_w, 2, 0, 12'h003), 1, 2, 32'h0000_0003, 0);
        add_row(1, r3_word(op_add_w, 3, 1, 2), 1, 3, 32'hffff_fffe, 0);
        add_row(1, r3_word(op_sub_w, 4, 2, 1), 1, 4, 32'h0000_0008, 0);
        add_row(1, r3_word(op_slt, 5, 1, 2), 1, 5, 32'h0000_0001, 0); // -5 < 3 signed.
        add_row(1, r3_word(op_sltu, 6, 1, 2), 1, 6, 32'h0000_0000, 0);
        add_row(1, r3_word(op_and, 7, 1, 2), 1, 7, 32'h0000_0003, 0);
        add_row(1, r3_word(op_or, 8, 1, 2), 1, 8, 32'hffff_fffb, 0);
        add_row(1, r3_word(op_xor, 9, 1, 2), 1, 9, 32'hffff_fff8, 0);
        add_row(1, r3_word(op_add_w, 10, 1, 1), 1, 10, 32'hffff_fff6, 0);
        add_row(2, ri12_word(op_addi_w, 11, 2, 12'h800), 1, 11, 32'hffff_f803, 0);
        add_row(2, ri12_word(op_slti, 12, 2, 12'h800), 1, 12, 32'h0000_0000, 0);
        add_row(2, ri12_word(op_sltui, 13, 2, 12'h800), 1, 13, 32'h0000_0001, 0);
        add_row(2, ri12_word(op_andi, 14, 1, 12'h800), 1, 14, 32'h0000_0800, 0);
        add_row(2, ri12_word(op_ori, 15, 2, 12'h800), 1, 15, 32'h0000_0803, 0);
        add_row(2, ri12_word(op_xori, 16, 1, 12'h800), 1, 16, 32'hffff_f7fb, 0);
        add_row(3, ri12_word(op_addi_w, 17, 0, 12'h001), 1, 17, 32'h0000_0001, 0);
        add_row(3, r3_word(op_add_w, 17, 17, 17), 1, 17, 32'h0000_0002, 0);
        add_row(3, r3_word(op_add_w, 17, 17, 17), 1, 17, 32'h0000_0004, 0);
        add_row(3, r3_word(op_add_w, 18, 17, 2), 1, 18, 32'h0000_0007, 0);
        add_row(3, r3_word(op_sub_w, 19, 17, 18), 1, 19, 32'hffff_fffd, 0);
        add_row(3, ri12_word(op_addi_w, 20, 0, 12'h00a), 1, 20, 32'h0000_000a, 0);
        add_row(3, ri12_word(op_addi_w, 20, 0, 12'h014), 1, 20, 32'h0000_0014, 0);
        add_row(3, r3_word(op_add_w, 21, 20, 0), 1, 21, 32'h0000_0014, 0); // younger r20 wins.
        add_row(4, ri12_word(op_addi_w, 0, 2, 12'h005), 0, 0, 32'h0000_0008, 0);
        add_row(4, r3_word(op_add_w, 22, 0, 2), 1, 22, 32'h0000_0003, 0);
        add_row(4, 32'hffff_ffe3, 0, 3, 32'h0000_0000, 1);
        add_row(4, r3_word(op_add_w, 23, 3, 0), 1, 23, 32'hffff_fffe, 0); // r3 kept its value.
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic send_row(input int idx, input logic timed);
        in_valid     = 1'b1;
        in_data.pc   = tab_pc[idx];
        in_data.inst = tab_inst[idx];
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        if (timed) begin
            accept_q.push_back(cycle + 1); // the transfer is on the next rising edge.
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic check_commit();
        int    r;
        int    start;
        string mode;
        if (seen >= 2 * nrows) begin
            errors++;
            $display("an extra commit with pc %h appeared after the last row", commit.pc);
        end else begin
            r    = seen % nrows;
            mode = (seen < nrows) ? "ready high" : "random ready";
            check_value("pc", commit.pc, tab_pc[r]);
            check_value("inst", commit.inst, tab_inst[r]);
            check_value("rf_wen", 32'(commit.rf_wen), tab_wen[r]);
            check_value("rf_wnum", 32'(commit.rf_wnum), tab_wnum[r]);
            check_value("illegal", 32'(commit.illegal), tab_ill[r]);
            if (tab_ill[r] == 0) begin
                check_value("rf_wdata", commit.rf_wdata, tab_wdata[r]);
            end
            if (seen < nrows) begin
                start = accept_q.pop_front();
                check_value("commit latency", 32'(cycle - start), 32'd2);
            end
            if (r == nrows - 1 || tab_group[r + 1] != tab_group[r]) begin
                if (errors == grp_err_start) begin
                    $display("test %s, %s: ok", group_name(tab_group[r]), mode);
                end else begin
                    $display("test %s, %s: %0d errors", group_name(tab_group[r]), mode,
                             errors - grp_err_start);
                end
                grp_err_start = errors;
            end
            seen++;
        end
    endtask

    // ****************************************
    // processes
    // ****************************************

    initial begin
        logic [31:0] rnd;
        commit_ready = 1'b0;
        void'($urandom(32'h180a));
        for (int i = 0; i < nrows; i++) begin
            rnd         = $urandom;
            idle_gap[i] = (rnd[2:0] == 3'b000); // an idle input cycle after this row.
        end
        forever begin
            @(posedge clk);
            #1;
            rnd          = $urandom;
            commit_ready = random_mode ? (rnd[1:0] != 2'b00) : 1'b1;
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (!rst_n && commit_valid) begin
                errors++;
                $display("a commit record appeared while reset was still asserted");
            end else if (rst_n && commit_valid && commit_ready) begin
                check_commit();
            end
        end
    end

    initial begin
        #(timeout_cycles * 10);
        $display("timeout: only %0d of %0d commits arrived in time", seen, 2 * nrows);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        build_table();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("in_ready after reset", 32'(in_ready), 32'd1);
        @(posedge clk);
        #1;
        for (int i = 0; i < nrows; i++) begin
            send_row(i, 1'b1);
        end
        wait (seen == nrows);
        random_mode = 1'b1;
        @(posedge clk);
        #1;
        for (int i = 0; i < nrows; i++) begin
            send_row(i, 1'b0);
            if (idle_gap[i]) begin
                @(posedge clk);
                #1;
            end
        end
        wait (seen == 2 * nrows);
        repeat (5) @(posedge clk);
        $display("summary: %0d commits, %0d checks, %0d errors", seen, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
